// ==== src/scope_consts.svh ====
// scope channel constants
// widths shared by the stream, config and datapath code

`ifndef SCOPE_CONSTS_SVH
`define SCOPE_CONSTS_SVH

// stream data
`define SCOPE_DWI 14  // adc sample width
`define SCOPE_DWO 14  // decimated sample width

// decimation
`define SCOPE_DWC 17  // group counter width
`define SCOPE_DWS 4   // right shift amount width

// acquisition
`define SCOPE_DWA 16  // pre/post counter width

`endif

// ==== src/scope_stream_pkg.sv ====
// scope stream beat types
// payloads carried on the valid/ready links between channel blocks

`include "scope_consts.svh"
`default_nettype none

package scope_stream_pkg;

  ////////////////////////////////////////
  // internal sample beat
  ////////////////////////////////////////

  // decimator -> edge detector -> acquisition
  typedef struct packed {
    logic signed [`SCOPE_DWO-1:0] dat;  // sample value
    logic                         trg;  // crossing completed on this sample
  } smp_beat_t;

  ////////////////////////////////////////
  // channel output beat
  ////////////////////////////////////////

  typedef struct packed {
    logic signed [`SCOPE_DWO-1:0] dat;  // sample value
    logic                         trg;  // accepted trigger sample
    logic                         lst;  // last sample of the window
  } acq_beat_t;

endpackage : scope_stream_pkg

`default_nettype wire

// ==== src/scope_cfg_pkg.sv ====
// scope channel configuration types
// static settings for decimation, trigger and acquisition window

`include "scope_consts.svh"
`default_nettype none

package scope_cfg_pkg;

  ////////////////////////////////////////
  // decimator / averager
  ////////////////////////////////////////

  typedef struct packed {
    logic                  avg;  // averaging enable
    logic [`SCOPE_DWC-1:0] dec;  // decimation factor, 0 acts as 1
    logic [`SCOPE_DWS-1:0] shf;  // arithmetic right shift of the sum
  } dec_cfg_t;

  ////////////////////////////////////////
  // trigger
  ////////////////////////////////////////

  typedef struct packed {
    logic signed [`SCOPE_DWO-1:0] lvl;  // level, signed
    logic        [`SCOPE_DWO-1:0] hys;  // hysteresis, unsigned
    logic                         neg;  // 1 = falling edge
    logic                         src;  // 0 = edge detector, 1 = trg_ext
  } trg_cfg_t;

  ////////////////////////////////////////
  // acquisition window
  ////////////////////////////////////////

  typedef struct packed {
    logic [`SCOPE_DWA-1:0] pre;  // beats forwarded before trigger can hit
    logic [`SCOPE_DWA-1:0] pst;  // beats forwarded after the trigger beat
  } acq_cfg_t;

endpackage : scope_cfg_pkg

`default_nettype wire

// ==== src/scope_dec_avg.sv ====
// decimator / averager
// sums groups of D accepted samples and emits one beat per group,
// either the arithmetically shifted sum or the group's last sample

`timescale 1ns/1ps
`include "scope_consts.svh"
`default_nettype none

module scope_dec_avg
  import scope_stream_pkg::*, scope_cfg_pkg::*;
(
  // system
  input  logic                         clk,
  input  logic                         rstn,     // sync, active low
  // control
  input  logic                         ctl_clr,  // sync clear strobe
  // configuration
  input  dec_cfg_t                     cfg,
  // stream in
  input  logic signed [`SCOPE_DWI-1:0] sti_dat,
  input  logic                         sti_vld,
  output logic                         sti_rdy,
  // stream out
  output smp_beat_t                    sto_beat,
  output logic                         sto_vld,
  input  logic                         sto_rdy
);

  localparam int DWM = `SCOPE_DWC + `SCOPE_DWI;  // accumulator width

  logic signed [DWM-1:0]        sum;      // running sum of the open group
  logic signed [DWM-1:0]        sum_nxt;  // sum with the incoming sample
  logic signed [DWM-1:0]        sum_shf;  // scaled group sum
  logic        [`SCOPE_DWC-1:0] cnt;      // samples taken in this group
  logic        [`SCOPE_DWC-1:0] cnt_nxt;
  logic                         sti_trn;  // input transfer
  logic                         grp_end;  // incoming sample closes the group

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  // ready when the output slot is free or being drained
  assign sti_rdy = sto_rdy | ~sto_vld;
  assign sti_trn = sti_vld & sti_rdy;

  ////////////////////////////////////////
  // group accounting
  ////////////////////////////////////////

  assign cnt_nxt = cnt + 1'b1;
  // compare against count+1, so dec of 0 closes every group like dec of 1
  assign grp_end = (cnt_nxt >= cfg.dec);

  assign sum_nxt = sum + sti_dat;       // sign extended add
  assign sum_shf = sum_nxt >>> cfg.shf; // arithmetic, keeps sign

  always_ff @(posedge clk) begin
    if (~rstn) begin
      sum     <= '0;
      cnt     <= '0;
      sto_vld <= 1'b0;
    end else if (ctl_clr) begin
      sum     <= '0;
      cnt     <= '0;
      sto_vld <= 1'b0;
    end else begin
      if (sti_trn) begin
        if (grp_end) begin
          sum <= '0;  // next accepted sample starts a fresh group
          cnt <= '0;
        end else begin
          sum <= sum_nxt;
          cnt <= cnt_nxt;
        end
      end
      // load on group end, hold while stalled
      sto_vld <= (sti_trn & grp_end) | (sto_vld & ~sto_rdy);
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (sti_trn & grp_end) begin
      if (cfg.avg) begin
        sto_beat.dat <= sum_shf[`SCOPE_DWO-1:0];  // low bits only
      end else begin
        sto_beat.dat <= sti_dat;  // plain decimation, D-th sample
      end
      sto_beat.trg <= 1'b0;  // no trigger info at this stage
    end
  end

endmodule : scope_dec_avg

`default_nettype wire

// ==== src/scope_edge.sv ====
// edge detector
// one-register stream stage, flags the sample completing a level
// crossing in the selected direction, with hysteresis for re-arming

`timescale 1ns/1ps
`include "scope_consts.svh"
`default_nettype none

module scope_edge
  import scope_stream_pkg::*, scope_cfg_pkg::*;
(
  // system
  input  logic      clk,
  input  logic      rstn,     // sync, active low
  // control
  input  logic      ctl_clr,  // sync clear strobe
  // configuration
  input  trg_cfg_t  cfg,
  // stream in
  input  smp_beat_t sti_beat,
  input  logic      sti_vld,
  output logic      sti_rdy,
  // stream out
  output smp_beat_t sto_beat,
  output logic      sto_vld,
  input  logic      sto_rdy
);

  logic signed [`SCOPE_DWO:0] dif;    // sample minus level, one bit wider
  logic signed [`SCOPE_DWO:0] hys_p;  // +hys
  logic signed [`SCOPE_DWO:0] hys_n;  // -hys
  logic                       arm;    // crossing armed
  logic                       sti_trn;
  logic                       arm_hit; // sample lies beyond the band
  logic                       fire;    // armed and sample reached the level

  assign sti_rdy = sto_rdy | ~sto_vld;
  assign sti_trn = sti_vld & sti_rdy;

  ////////////////////////////////////////
  // compare
  ////////////////////////////////////////

  assign dif   = sti_beat.dat - cfg.lvl;
  assign hys_p = $signed({1'b0, cfg.hys});
  assign hys_n = -hys_p;

  // rising: arm below lvl-hys, fire at or above lvl
  // falling: arm above lvl+hys, fire at or below lvl
  assign arm_hit = cfg.neg ? (dif > hys_p) : (dif < hys_n);
  assign fire    = arm & (cfg.neg ? (dif <= 0) : (dif >= 0));

  ////////////////////////////////////////
  // control state
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (~rstn) begin
      arm     <= 1'b0;
      sto_vld <= 1'b0;
    end else if (ctl_clr) begin
      arm     <= 1'b0;
      sto_vld <= 1'b0;
    end else begin
      if (sti_trn) begin
        if (fire) begin
          arm <= 1'b0;  // one trigger per arming
        end else if (arm_hit) begin
          arm <= 1'b1;
        end
      end
      sto_vld <= sti_trn | (sto_vld & ~sto_rdy);
    end
  end

  // payload, one cycle latency
  always_ff @(posedge clk) begin
    if (sti_trn) begin
      sto_beat.dat <= sti_beat.dat;
      sto_beat.trg <= fire;
    end
  end

endmodule : scope_edge

`default_nettype wire

// ==== src/scope_acq.sv ====
// acquisition controller
// gates the sample stream into a window of pre-trigger and post-trigger
// beats, picks edge or external trigger, marks trg and lst on output

`timescale 1ns/1ps
`include "scope_consts.svh"
`default_nettype none

module scope_acq
  import scope_stream_pkg::*, scope_cfg_pkg::*;
(
  // system
  input  logic      clk,
  input  logic      rstn,       // sync, active low
  // control
  input  logic      ctl_clr,    // sync clear strobe
  input  logic      ctl_start,  // start strobe
  // configuration
  input  acq_cfg_t  cfg,
  input  logic      src,        // 0 = edge trg flag, 1 = trg_ext
  // external trigger level
  input  logic      trg_ext,
  // stream in
  input  smp_beat_t sti_beat,
  input  logic      sti_vld,
  output logic      sti_rdy,
  // stream out
  output acq_beat_t sto_beat,
  output logic      sto_vld,
  input  logic      sto_rdy,
  // status
  output logic      sts_run,
  output logic      sts_trg
);

  localparam logic [1:0] ST_IDLE = 2'd0;  // dropping beats
  localparam logic [1:0] ST_PRE  = 2'd1;  // forwarding, waiting for trigger
  localparam logic [1:0] ST_PST  = 2'd2;  // forwarding after trigger

  logic [1:0]            state;
  logic [`SCOPE_DWA-1:0] cnt;       // forwarded beats in pre, saturates
  logic [`SCOPE_DWA-1:0] cnt_nxt;
  logic [`SCOPE_DWA-1:0] pcnt;      // forwarded beats after trigger
  logic [`SCOPE_DWA-1:0] pcnt_nxt;
  logic                  ext_q;     // trg_ext delayed
  logic                  ext_pnd;   // external edge seen, waiting for a beat
  logic                  ext_rise;
  logic                  armed;     // pre count reached
  logic                  start;
  logic                  fwd;       // beat forwarded this cycle
  logic                  trg_hit;   // forwarded beat is the trigger
  logic                  lst_hit;   // forwarded beat closes the window
  logic                  sto_trn;
  logic                  lst_trn;   // last beat leaves the block

  ////////////////////////////////////////
  // handshake and decode
  ////////////////////////////////////////

  // idle swallows everything, otherwise a normal register stage
  assign sti_rdy = (state == ST_IDLE) | sto_rdy | ~sto_vld;
  assign fwd     = sti_vld & sti_rdy & (state != ST_IDLE);
  assign sto_trn = sto_vld & sto_rdy;
  assign lst_trn = sto_trn & sto_beat.lst;

  // sts_run also covers the drain of the lst beat
  assign start = ctl_start & ~sts_run;

  assign cnt_nxt  = cnt + 1'b1;
  assign pcnt_nxt = pcnt + 1'b1;
  assign armed    = (state == ST_PRE) & (cnt >= cfg.pre);
  assign ext_rise = trg_ext & ~ext_q;

  assign trg_hit = fwd & armed & (src ? ext_pnd : sti_beat.trg);
  assign lst_hit = (trg_hit & (cfg.pst == '0))
                 | (fwd & (state == ST_PST) & (pcnt_nxt == cfg.pst));

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (~rstn) begin
      state   <= ST_IDLE;
      cnt     <= '0;
      pcnt    <= '0;
      ext_q   <= 1'b0;
      ext_pnd <= 1'b0;
      sto_vld <= 1'b0;
      sts_run <= 1'b0;
      sts_trg <= 1'b0;
    end else begin
      ext_q <= trg_ext;  // edge register runs regardless of state
      if (ctl_clr) begin
        state   <= ST_IDLE;
        cnt     <= '0;
        pcnt    <= '0;
        ext_pnd <= 1'b0;
        sto_vld <= 1'b0;
        sts_run <= 1'b0;
        sts_trg <= 1'b0;
      end else begin
        case (state)
          ST_IDLE: begin
            if (start) begin
              state   <= ST_PRE;
              cnt     <= '0;
              ext_pnd <= 1'b0;
            end
          end
          ST_PRE: begin
            if (fwd & ~armed) cnt <= cnt_nxt;  // stop once armed
            if (ext_rise & armed) ext_pnd <= 1'b1;
            if (trg_hit) begin
              ext_pnd <= 1'b0;
              pcnt    <= '0;
              state   <= lst_hit ? ST_IDLE : ST_PST;  // pst of 0 ends here
            end
          end
          ST_PST: begin
            if (fwd) begin
              pcnt <= pcnt_nxt;
              if (lst_hit) state <= ST_IDLE;
            end
          end
          default: state <= ST_IDLE;
        endcase

        sto_vld <= fwd | (sto_vld & ~sto_rdy);

        // status levels, both fall with the lst transfer
        if (start) begin
          sts_run <= 1'b1;
        end else if (lst_trn) begin
          sts_run <= 1'b0;
        end
        if (trg_hit) begin
          sts_trg <= 1'b1;
        end else if (lst_trn) begin
          sts_trg <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fwd) begin
      sto_beat.dat <= sti_beat.dat;
      sto_beat.trg <= trg_hit;  // only the accepted trigger
      sto_beat.lst <= lst_hit;
    end
  end

endmodule : scope_acq

`default_nettype wire

// ==== src/scope_top.sv ====
// scope acquisition channel
// decimator -> edge detector -> acquisition controller, all on
// valid/ready links with one register per stage

`timescale 1ns/1ps
`include "scope_consts.svh"
`default_nettype none

module scope_top
  import scope_stream_pkg::*, scope_cfg_pkg::*;
(
  // system
  input  logic                         clk,
  input  logic                         rstn,       // sync, active low
  // control
  input  logic                         ctl_clr,    // clear all stages
  input  logic                         ctl_start,  // start acquisition
  // configuration
  input  dec_cfg_t                     dec_cfg,
  input  trg_cfg_t                     trg_cfg,
  input  acq_cfg_t                     acq_cfg,
  // adc stream
  input  logic signed [`SCOPE_DWI-1:0] sti_dat,
  input  logic                         sti_vld,
  output logic                         sti_rdy,
  // external trigger
  input  logic                         trg_ext,
  // acquired stream
  output acq_beat_t                    acq_beat,
  output logic                         acq_vld,
  input  logic                         acq_rdy,
  // status
  output logic                         sts_run,
  output logic                         sts_trg
);

  smp_beat_t dec_beat;  // decimated samples
  logic      dec_vld;
  logic      dec_rdy;
  smp_beat_t edg_beat;  // samples with edge flag
  logic      edg_vld;
  logic      edg_rdy;

  ////////////////////////////////////////
  // stages
  ////////////////////////////////////////

  scope_dec_avg u_dec (
    .clk      (clk),
    .rstn     (rstn),
    .ctl_clr  (ctl_clr),
    .cfg      (dec_cfg),
    .sti_dat  (sti_dat),
    .sti_vld  (sti_vld),
    .sti_rdy  (sti_rdy),
    .sto_beat (dec_beat),
    .sto_vld  (dec_vld),
    .sto_rdy  (dec_rdy)
  );

  scope_edge u_edg (
    .clk      (clk),
    .rstn     (rstn),
    .ctl_clr  (ctl_clr),
    .cfg      (trg_cfg),
    .sti_beat (dec_beat),
    .sti_vld  (dec_vld),
    .sti_rdy  (dec_rdy),
    .sto_beat (edg_beat),
    .sto_vld  (edg_vld),
    .sto_rdy  (edg_rdy)
  );

  scope_acq u_acq (
    .clk       (clk),
    .rstn      (rstn),
    .ctl_clr   (ctl_clr),
    .ctl_start (ctl_start),
    .cfg       (acq_cfg),
    .src       (trg_cfg.src),  // trigger source lives in trigger config
    .trg_ext   (trg_ext),
    .sti_beat  (edg_beat),
    .sti_vld   (edg_vld),
    .sti_rdy   (edg_rdy),
    .sto_beat  (acq_beat),
    .sto_vld   (acq_vld),
    .sto_rdy   (acq_rdy),
    .sts_run   (sts_run),
    .sts_trg   (sts_trg)
  );

endmodule : scope_top

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
// testbench clock and reset
// free running clock, reset held low for the first few rising edges

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real PERIOD  = 4.0,  // ns
  parameter int  RST_CYC = 4     // cycles with rstn low
) (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

  // sync release on a rising edge
  initial begin
    rstn = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    rstn <= 1'b1;
  end

endmodule : tb_clk_gen

`default_nettype wire

// ==== tests/tb_scope.sv ====
// scope channel testbench
// drives sample streams through the channel, predicts the edge link
// and output beats with a reference model, checks them with assertions

`timescale 1ns/1ps
`include "scope_consts.svh"
`default_nettype none

module tb_scope
  import scope_stream_pkg::*, scope_cfg_pkg::*;
();

  // input samples per test
  localparam int N_T1 = 32;  // also reused by test 3
  localparam int N_T2 = 64;
  localparam int N_T4 = 74;  // both edge runs
  localparam int N_T5 = 80;
  localparam int N_T6 = 19;
  localparam int CYC_LIMIT = 4 * (N_T1 * 4 + N_T2 * 8 + N_T1 * 4 + N_T4 + N_T5 * 2 + N_T6) + 200;

  logic clk, rstn;
  logic ctl_clr, ctl_start, trg_ext;
  dec_cfg_t dec_cfg;
  trg_cfg_t trg_cfg;
  acq_cfg_t acq_cfg;
  logic signed [`SCOPE_DWI-1:0] sti_dat;
  logic sti_vld, sti_rdy;
  acq_beat_t acq_beat;
  logic acq_vld, acq_rdy, sts_run, sts_trg;

  integer seed = 5669;
  integer rdy_seed = 5669 + 1;  // separate stream for the ready pattern
  logic signed [`SCOPE_DWI-1:0] in_q[$];    // samples still to send
  logic signed [`SCOPE_DWI-1:0] t1_smp[$];  // test 1 stimulus, replayed in test 3
  logic signed [`SCOPE_DWI-1:0] smp;
  smp_beat_t edg_q[$];  // expected edge link beats
  acq_beat_t out_q[$];  // expected channel output beats
  acq_beat_t prev_beat;
  logic rdy_rnd = 1'b0;
  bit hold_prev = 0, lst_prev = 0;
  integer err_cnt = 0, err_mark = 0, pass_cnt = 0, fail_cnt = 0;
  integer cyc = 0, post_seen = 0, lst_cnt = 0, lst_mark, i;
  // reference model state
  integer m_sum, m_cnt, m_fwd, m_pcnt;
  bit m_arm, m_run, m_trg, m_pnd;

  tb_clk_gen u_clk (.clk(clk), .rstn(rstn));

  scope_top UUT (
    .clk(clk), .rstn(rstn), .ctl_clr(ctl_clr), .ctl_start(ctl_start),
    .dec_cfg(dec_cfg), .trg_cfg(trg_cfg), .acq_cfg(acq_cfg),
    .sti_dat(sti_dat), .sti_vld(sti_vld), .sti_rdy(sti_rdy), .trg_ext(trg_ext),
    .acq_beat(acq_beat), .acq_vld(acq_vld), .acq_rdy(acq_rdy),
    .sts_run(sts_run), .sts_trg(sts_trg)
  );

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  task model_clear();
    m_sum = 0; m_cnt = 0; m_arm = 0;
    m_run = 0; m_trg = 0; m_pnd = 0; m_fwd = 0; m_pcnt = 0;
  endtask

  task model_start();
    m_run = 1; m_fwd = 0; m_trg = 0; m_pnd = 0; m_pcnt = 0;
  endtask

  // external edge counts only once pre beats went out
  task model_ext();
    if (m_run && !m_trg && m_fwd >= acq_cfg.pre) m_pnd = 1;
  endtask

  task model_beat(input logic signed [`SCOPE_DWO-1:0] d);
    integer s, l, h;
    bit fire, hit, lst;
    smp_beat_t eb;
    acq_beat_t ob;
    s = d;
    l = $signed(trg_cfg.lvl);
    h = trg_cfg.hys;  // unsigned band
    fire = 0;
    if (trg_cfg.neg) begin
      if (m_arm && s <= l) begin
        fire = 1;
        m_arm = 0;
      end else if (s > l + h) m_arm = 1;  // above band
    end else begin
      if (m_arm && s >= l) begin
        fire = 1;
        m_arm = 0;
      end else if (s < l - h) m_arm = 1;  // below band
    end
    eb.dat = d;
    eb.trg = fire;
    edg_q.push_back(eb);
    if (m_run) begin  // idle drops the beat
      hit = 0;
      lst = 0;
      if (m_trg) begin
        m_pcnt++;
        lst = (m_pcnt == acq_cfg.pst);
      end else if (m_fwd >= acq_cfg.pre && (trg_cfg.src ? m_pnd : fire)) begin
        hit = 1;
        m_trg = 1;
        m_pnd = 0;
        lst = (acq_cfg.pst == 0);
      end else m_fwd++;
      ob.dat = d;
      ob.trg = hit;
      ob.lst = lst;
      out_q.push_back(ob);
      if (lst) m_run = 0;
    end
  endtask

  task model_sample(input logic signed [`SCOPE_DWI-1:0] v);
    integer d_f, r;
    logic signed [`SCOPE_DWO-1:0] o;
    d_f = (dec_cfg.dec == 0) ? 1 : dec_cfg.dec;
    m_sum = m_sum + v;
    m_cnt++;
    if (m_cnt >= d_f) begin  // group closes
      r = m_sum >>> dec_cfg.shf;
      o = dec_cfg.avg ? r[`SCOPE_DWO-1:0] : v;
      m_sum = 0;
      m_cnt = 0;
      model_beat(o);
    end
  endtask

  ////////////////////////////////////////
  // checkers
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (rstn) begin
      // internal edge link, shows every crossing
      if (UUT.edg_vld && UUT.edg_rdy) begin
        if (edg_q.size() == 0) begin
          $display("FAIL %0t: unexpected beat on edge link", $time);
          err_cnt++;
        end else begin
          assert (UUT.edg_beat == edg_q[0]) else begin
            $display("FAIL %0t: edge link dat %0d trg %0b, expected dat %0d trg %0b", $time,
                     UUT.edg_beat.dat, UUT.edg_beat.trg, edg_q[0].dat, edg_q[0].trg);
            err_cnt++;
          end
          void'(edg_q.pop_front());
        end
      end
      if (acq_vld && acq_rdy) begin
        if (out_q.size() == 0) begin
          $display("FAIL %0t: unexpected output beat dat %0d", $time, acq_beat.dat);
          err_cnt++;
        end else begin
          assert (acq_beat == out_q[0]) else begin
            $display("FAIL %0t: out dat %0d trg %0b lst %0b, expected %0d %0b %0b", $time,
                     acq_beat.dat, acq_beat.trg, acq_beat.lst,
                     out_q[0].dat, out_q[0].trg, out_q[0].lst);
            err_cnt++;
          end
          void'(out_q.pop_front());
        end
        assert (sts_run && (!acq_beat.trg || sts_trg)) else begin
          $display("FAIL %0t: status low during output transfer", $time);
          err_cnt++;
        end
        if (acq_beat.trg) post_seen = 0;
        else post_seen++;
        if (acq_beat.lst) begin
          assert (post_seen == acq_cfg.pst) else begin
            $display("FAIL %0t: %0d beats after trigger, expected %0d", $time,
                     post_seen, acq_cfg.pst);
            err_cnt++;
          end
          lst_cnt++;
        end
      end
      // stalled beat must not move
      if (hold_prev) begin
        assert (acq_vld && acq_beat == prev_beat) else begin
          $display("FAIL %0t: output beat changed while stalled", $time);
          err_cnt++;
        end
      end
      if (lst_prev) begin
        assert (!sts_run && !sts_trg) else begin
          $display("FAIL %0t: status still high after last beat", $time);
          err_cnt++;
        end
      end
      hold_prev = acq_vld && !acq_rdy;
      prev_beat = acq_beat;
      lst_prev  = acq_vld && acq_rdy && acq_beat.lst;
    end
  end

  // downstream ready, random only in test 3
  always @(posedge clk) begin
    if (rdy_rnd) acq_rdy <= (($random(rdy_seed) & 1) != 0);
    else acq_rdy <= 1'b1;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYC_LIMIT) begin
      $display("timeout: run still going after %0d cycles", cyc);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  task configure(input bit avg, input int dec, input int shf, input int lvl, input int hys,
                 input bit neg, input bit src, input int pre, input int pst);
    dec_cfg.avg <= avg;
    dec_cfg.dec <= dec;
    dec_cfg.shf <= shf;
    trg_cfg.lvl <= lvl;
    trg_cfg.hys <= hys;
    trg_cfg.neg <= neg;
    trg_cfg.src <= src;
    acq_cfg.pre <= pre;
    acq_cfg.pst <= pst;
  endtask

  task clear_pulse();
    @(posedge clk);
    ctl_clr <= 1'b1;
    @(posedge clk);
    ctl_clr <= 1'b0;
    model_clear();
  endtask

  task start_pulse();
    ctl_start <= 1'b1;
    @(posedge clk);
    ctl_start <= 1'b0;
    model_start();
  endtask

  // push queued samples, optional random gaps on sti_vld
  task send_all(input bit gaps);
    sti_dat <= in_q[0];
    sti_vld <= 1'b1;
    while (in_q.size() > 0) begin
      @(posedge clk);
      if (sti_vld && sti_rdy) begin
        model_sample(in_q.pop_front());
        if (in_q.size() > 0) begin
          sti_dat <= in_q[0];
          sti_vld <= gaps ? (($random(seed) & 1) != 0) : 1'b1;
        end else sti_vld <= 1'b0;
      end else if (!sti_vld) begin
        sti_vld <= gaps ? (($random(seed) & 1) != 0) : 1'b1;
      end
    end
  endtask

  task drain();
    while (edg_q.size() != 0 || out_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  task step(input int v);  // one sample through the whole pipe
    in_q.push_back(v);
    send_all(0);
    drain();
  endtask

  task pulse_ext();
    trg_ext <= 1'b1;
    model_ext();
    repeat (2) @(posedge clk);
    trg_ext <= 1'b0;
    @(posedge clk);
  endtask

  task add_ramp(input int from, input int to, input int stp);
    int v;
    for (v = from; (stp > 0) ? (v <= to) : (v >= to); v += stp) in_q.push_back(v);
  endtask

  task end_test(input string name);
    if (err_cnt == err_mark) begin
      pass_cnt++;
      $display("test %s: pass", name);
    end else begin
      fail_cnt++;
      $display("test %s: fail, %0d errors", name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  initial begin
    ctl_clr = 1'b0; ctl_start = 1'b0; trg_ext = 1'b0;
    sti_dat = '0; sti_vld = 1'b0; acq_rdy = 1'b1;
    dec_cfg = '0; trg_cfg = '0; acq_cfg = '0;
    model_clear();
    wait (rstn === 1'b1);
    @(posedge clk);

    // 1: plain decimation, trigger level out of reach
    for (i = 0; i < N_T1; i++) begin
      smp = $random(seed) % 8192;
      t1_smp.push_back(smp);
    end
    configure(0, 4, 0, -8192, 0, 0, 0, 0, 0);
    clear_pulse();
    start_pulse();
    foreach (t1_smp[i]) in_q.push_back(t1_smp[i]);
    send_all(0);
    drain();
    end_test("1 decimation");

    // 2: averaging, full range so sums go negative
    configure(1, 8, 3, -8192, 0, 0, 0, 0, 0);
    clear_pulse();
    start_pulse();
    for (i = 0; i < N_T2; i++) begin
      smp = $random(seed) % 8192;
      in_q.push_back(smp);
    end
    send_all(0);
    drain();
    end_test("2 averaging");

    // 3: test 1 again under random valid and ready
    configure(0, 4, 0, -8192, 0, 0, 0, 0, 0);
    rdy_rnd <= 1'b1;
    clear_pulse();
    start_pulse();
    foreach (t1_smp[i]) in_q.push_back(t1_smp[i]);
    send_all(1);
    drain();
    rdy_rnd <= 1'b0;
    end_test("3 back-pressure");

    // 4: ramp, in-band wobble, then sawtooth, rising then falling
    configure(0, 1, 0, 100, 50, 0, 0, 2, 3);
    clear_pulse();
    start_pulse();
    add_ramp(-200, 300, 25);
    add_ramp(60, 110, 50);  // stays inside band, no re-arm
    add_ramp(60, 110, 50);
    repeat (3) add_ramp(0, 150, 50);
    send_all(0);
    drain();
    configure(0, 1, 0, -100, 50, 1, 0, 2, 3);
    clear_pulse();
    start_pulse();
    add_ramp(200, -300, -25);
    add_ramp(-60, -110, -50);
    add_ramp(-60, -110, -50);
    repeat (3) add_ramp(0, -150, -50);
    send_all(0);
    drain();
    end_test("4 edge trigger");

    // 5: square wave with noise, first crossing falls inside pre
    configure(1, 2, 1, 0, 100, 0, 0, 5, 7);
    clear_pulse();
    start_pulse();
    lst_mark = lst_cnt;
    for (i = 0; i < N_T5; i++) begin
      smp = (((i / 8) % 2) ? 2000 : -2000) + ($random(seed) % 64);
      in_q.push_back(smp);
    end
    send_all(0);
    drain();
    if (lst_cnt != lst_mark + 1 || sts_run || sts_trg) begin
      $display("test 5: acquisition window did not close with status low");
      err_cnt++;
    end
    end_test("5 acquisition window");

    // 6a: external trigger, first edge too early, second one counts
    configure(0, 1, 0, -8192, 0, 0, 1, 3, 4);
    clear_pulse();
    start_pulse();
    lst_mark = lst_cnt;
    for (i = 0; i < 11; i++) begin
      if (i == 1 || i == 4) pulse_ext();
      step(i * 100 - 300);
    end
    if (lst_cnt != lst_mark + 1) begin
      $display("test 6: external trigger window did not close");
      err_cnt++;
    end
    // 6b: clear in the middle of a window
    clear_pulse();
    start_pulse();
    for (i = 0; i < 3; i++) step(i * 7);
    if (!sts_run) begin
      $display("test 6: sts_run low during acquisition");
      err_cnt++;
    end
    clear_pulse();
    @(posedge clk);
    if (sts_run || sts_trg) begin
      $display("test 6: status still high after clear");
      err_cnt++;
    end
    for (i = 0; i < 3; i++) step(-i * 9);  // idle, nothing may come out
    start_pulse();
    for (i = 0; i < 2; i++) step(500 + i);
    end_test("6 external trigger and clear");

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : tb_scope

`default_nettype wire

// ==== sim.f ====
+incdir+src
src/scope_stream_pkg.sv
src/scope_cfg_pkg.sv
src/scope_dec_avg.sv
src/scope_edge.sv
src/scope_acq.sv
src/scope_top.sv
tests/tb_clk_gen.sv
tests/tb_scope.sv
